// ==== tb.f ====
hdl/core_cfg_pkg.sv
hdl/la32_isa_pkg.sv
hdl/issue_slot_if.sv
hdl/wb_port_if.sv
hdl/register_file.sv
hdl/dual_decode.sv
hdl/dual_execute.sv
hdl/dual_result.sv
hdl/dual_core_top.sv
testbench/tb_dual_core.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_dual_core
FILELIST = tb.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== testbench/tb_dual_core.sv ====
`timescale 1ns/1ns

module tb_dual_core;
    import core_cfg_pkg::*;
    import la32_isa_pkg::*;

    localparam int MAX_ROWS   = 64;
    localparam int DRAIN_WAIT = 50;

    typedef struct packed {
        logic      we0;
        reg_addr_t addr0;
        word_t     data0;
        logic      we1;
        reg_addr_t addr1;
        word_t     data1;
    } commit_t;

    logic      clk;
    logic      rstn;
    logic      issue_valid;
    word_t     inst0;
    word_t     inst1;
    reg_addr_t dbg_reg_num;
    logic      commit_valid;
    logic      commit_we0;
    reg_addr_t commit_addr0;
    word_t     commit_data0;
    logic      commit_we1;
    reg_addr_t commit_addr1;
    word_t     commit_data1;
    word_t     dbg_reg_data;

    logic    row_valid [MAX_ROWS];
    word_t   row_inst0 [MAX_ROWS];
    word_t   row_inst1 [MAX_ROWS];
    int      n_rows;
    word_t   ref_regs [NREG];   // Architectural state after the last issued pair
    commit_t exp_q [$];
    integer  seed = 71;
    int      wait_cycles;

    dual_core_top i_dut (
        .clk          (clk),
        .rstn         (rstn),
        .issue_valid  (issue_valid),
        .inst0        (inst0),
        .inst1        (inst1),
        .dbg_reg_num  (dbg_reg_num),
        .commit_valid (commit_valid),
        .commit_we0   (commit_we0),
        .commit_addr0 (commit_addr0),
        .commit_data0 (commit_data0),
        .commit_we1   (commit_we1),
        .commit_addr1 (commit_addr1),
        .commit_data1 (commit_data1),
        .dbg_reg_data (dbg_reg_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Failure reporting and compares
    task automatic abort_run(string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_word(string name, word_t exp, word_t act);
        if (act !== exp) abort_run($sformatf("error %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_addr(string name, reg_addr_t exp, reg_addr_t act);
        if (act !== exp) abort_run($sformatf("error %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) abort_run($sformatf("error %s expected %h actual %h", name, exp, act));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction encoders
    function automatic word_t enc_3r(logic [OP3R_W-1:0] opc, reg_addr_t rd, reg_addr_t rj,
                                     reg_addr_t rk);
        return {opc, rk, rj, rd};
    endfunction

    function automatic word_t enc_ri12(logic [OP12_W-1:0] opc, reg_addr_t rd, reg_addr_t rj,
                                       logic [11:0] imm);
        return {opc, imm, rj, rd};
    endfunction

    function automatic word_t enc_ri20(logic [OP20_W-1:0] opc, reg_addr_t rd, logic [19:0] imm);
        return {opc, imm, rd};
    endfunction

    task automatic add_row(logic v, word_t w0, word_t w1);
        row_valid[n_rows] = v;
        row_inst0[n_rows] = w0;
        row_inst1[n_rows] = w1;
        n_rows++;
    endtask

    task automatic gen_random_inst(output word_t w);
        int          pick;
        reg_addr_t   rd;
        reg_addr_t   rj;
        reg_addr_t   rk;
        logic [11:0] i12;
        logic [19:0] i20;
        pick = {$random(seed)} % 10;
        rd   = reg_addr_t'({$random(seed)} % 16);   // Low registers for more hazards
        rj   = reg_addr_t'({$random(seed)} % 16);
        rk   = reg_addr_t'({$random(seed)} % 16);
        i12  = 12'($random(seed));
        i20  = 20'($random(seed));
        case (pick)
            0:       w = enc_3r(OPC_ADD_W, rd, rj, rk);
            1:       w = enc_3r(OPC_SUB_W, rd, rj, rk);
            2:       w = enc_3r(OPC_SLT, rd, rj, rk);
            3:       w = enc_3r(OPC_SLTU, rd, rj, rk);
            4:       w = enc_3r(OPC_AND, rd, rj, rk);
            5:       w = enc_3r(OPC_OR, rd, rj, rk);
            6:       w = enc_3r(OPC_XOR, rd, rj, rk);
            7:       w = enc_ri12(OPC_ADDI_W, rd, rj, i12);
            8:       w = enc_ri12(OPC_ORI, rd, rj, i12);
            default: w = enc_ri20(OPC_LU12I_W, rd, i20);
        endcase
    endtask

    task automatic build_table();
        word_t w0;
        word_t w1;
        add_row(1, enc_ri20(OPC_LU12I_W, 5'd1, 20'h80000),
                enc_ri12(OPC_ADDI_W, 5'd2, 5'd0, 12'hfff));
        add_row(1, enc_ri12(OPC_ORI, 5'd3, 5'd0, 12'hfff),
                enc_ri12(OPC_ADDI_W, 5'd4, 5'd0, 12'h7ff));
        add_row(1, enc_3r(OPC_SLT, 5'd5, 5'd1, 5'd4), enc_3r(OPC_SLTU, 5'd6, 5'd1, 5'd4));
        add_row(1, enc_3r(OPC_ADD_W, 5'd7, 5'd2, 5'd3), enc_3r(OPC_SUB_W, 5'd8, 5'd1, 5'd4));
        add_row(1, enc_3r(OPC_AND, 5'd9, 5'd2, 5'd3), enc_3r(OPC_OR, 5'd10, 5'd1, 5'd3));
        add_row(1, enc_3r(OPC_XOR, 5'd11, 5'd7, 5'd8), enc_3r(OPC_SLTU, 5'd26, 5'd4, 5'd1));
        add_row(1, enc_3r(OPC_ADD_W, 5'd12, 5'd1, 5'd2), enc_3r(OPC_SUB_W, 5'd12, 5'd3, 5'd4));
        add_row(1, enc_ri12(OPC_ADDI_W, 5'd13, 5'd0, 12'd5),
                enc_ri12(OPC_ADDI_W, 5'd14, 5'd13, 12'd1));
        add_row(1, enc_ri12(OPC_ADDI_W, 5'd0, 5'd3, 12'd1),
                enc_ri12(OPC_ORI, 5'd15, 5'd0, 12'h123));
        add_row(0, enc_3r(OPC_ADD_W, 5'd27, 5'd1, 5'd1), enc_3r(OPC_ADD_W, 5'd28, 5'd2, 5'd2));
        add_row(1, 32'hffff_ffff, 32'h0000_0000);  // Unknown words
        add_row(1, enc_ri12(OPC_ADDI_W, 5'd16, 5'd12, 12'd1),
                enc_ri12(OPC_ADDI_W, 5'd17, 5'd16, 12'd2));
        add_row(1, enc_ri12(OPC_ADDI_W, 5'd18, 5'd16, 12'd3),
                enc_3r(OPC_ADD_W, 5'd19, 5'd17, 5'd12));
        add_row(0, 32'h0, 32'h0);
        add_row(1, enc_3r(OPC_ADD_W, 5'd20, 5'd18, 5'd19), enc_3r(OPC_XOR, 5'd29, 5'd16, 5'd0));
        add_row(1, enc_ri20(OPC_LU12I_W, 5'd21, 20'h12345),
                enc_ri12(OPC_ORI, 5'd22, 5'd21, 12'h678));
        add_row(1, enc_3r(OPC_OR, 5'd23, 5'd21, 5'd22), enc_3r(OPC_ADD_W, 5'd0, 5'd1, 5'd2));
        add_row(1, enc_3r(OPC_SLTU, 5'd24, 5'd2, 5'd3), enc_3r(OPC_SLT, 5'd25, 5'd2, 5'd3));
        // Random pairs, about one bubble in eight
        for (int i = 0; i < 40; i++) begin
            gen_random_inst(w0);
            gen_random_inst(w1);
            add_row(({$random(seed)} % 8) != 0, w0, w1);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model, one lane against the state before its pair
    task automatic model_lane(input word_t w, output logic we, output reg_addr_t rd,
                              output word_t val);
        word_t a;
        word_t b;
        rd  = w[4:0];
        a   = ref_regs[w[9:5]];
        b   = ref_regs[w[14:10]];
        we  = 1'b1;
        val = '0;
        case (w[31:15])
            OPC_ADD_W: val = a + b;
            OPC_SUB_W: val = a - b;
            OPC_SLT:   val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OPC_SLTU:  val = (a < b) ? 32'd1 : 32'd0;
            OPC_AND:   val = a & b;
            OPC_OR:    val = a | b;
            OPC_XOR:   val = a ^ b;
            default:   we = 1'b0;
        endcase
        if (!we) begin
            we = 1'b1;
            if (w[31:22] == OPC_ADDI_W) val = a + {{20{w[21]}}, w[21:10]};
            else if (w[31:22] == OPC_ORI) val = a | {20'h0, w[21:10]};
            else if (w[31:25] == OPC_LU12I_W) val = {w[24:5], 12'h000};
            else we = 1'b0;
        end
        if (rd == 5'd0) we = 1'b0;   // r0 is never written
    endtask

    task automatic issue_row(int i);
        commit_t   e;
        logic      we0;
        logic      we1;
        reg_addr_t a0;
        reg_addr_t a1;
        word_t     v0;
        word_t     v1;
        @(posedge clk);
        #1;
        issue_valid = row_valid[i];
        inst0       = row_inst0[i];
        inst1       = row_inst1[i];
        if (row_valid[i]) begin
            model_lane(inst0, we0, a0, v0);
            model_lane(inst1, we1, a1, v1);
            e.we0   = we0 && !(we1 && (a1 == a0));   // Lane 1 wins a shared destination
            e.addr0 = a0;
            e.data0 = v0;
            e.we1   = we1;
            e.addr1 = a1;
            e.data1 = v1;
            if (e.we0) ref_regs[a0] = v0;
            if (we1) ref_regs[a1] = v1;
            exp_q.push_back(e);
        end
    endtask

    // Debug port sweep against the reference array
    task automatic compare_regs();
        for (int r = 0; r < NREG; r++) begin
            @(posedge clk);
            #1 dbg_reg_num = reg_addr_t'(r);
            @(negedge clk);
            check_word($sformatf("dbg_reg_data[%0d]", r), ref_regs[r], dbg_reg_data);
        end
    endtask

    // Commit monitor, sampled mid-cycle
    always @(negedge clk) begin
        commit_t e;
        if (rstn && commit_valid) begin
            if (exp_q.size() == 0) begin
                abort_run("commit_valid went high with no issued pair in flight");
            end else begin
                e = exp_q.pop_front();
                check_bit("commit_we0", e.we0, commit_we0);
                check_bit("commit_we1", e.we1, commit_we1);
                if (e.we0) check_addr("commit_addr0", e.addr0, commit_addr0);
                if (e.we0) check_word("commit_data0", e.data0, commit_data0);
                if (e.we1) check_addr("commit_addr1", e.addr1, commit_addr1);
                if (e.we1) check_word("commit_data1", e.data1, commit_data1);
            end
        end
    end

    initial begin
        rstn        = 1'b0;
        issue_valid = 1'b0;
        inst0       = '0;
        inst1       = '0;
        dbg_reg_num = '0;
        n_rows      = 0;
        for (int r = 0; r < NREG; r++) ref_regs[r] = '0;
        build_table();
        repeat (10) @(posedge clk);
        #1 rstn = 1'b1;
        repeat (4) @(posedge clk);   // Idle, monitor flags any commit
        compare_regs();              // All zero out of reset

        for (int i = 0; i < n_rows; i++) issue_row(i);
        @(posedge clk);
        #1 issue_valid = 1'b0;

        wait_cycles = 0;
        while ((exp_q.size() != 0) && (wait_cycles < DRAIN_WAIT)) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (exp_q.size() != 0) abort_run("commits stopped arriving with pairs still outstanding");
        repeat (3) @(posedge clk);   // Last writeback reaches the register file
        compare_regs();

        $display("** PASS **");
        $finish;
    end

endmodule

// ==== hdl/dual_core_top.sv ====
`timescale 1ns/1ns

module dual_core_top (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    issue_valid,
    input  core_cfg_pkg::word_t     inst0,
    input  core_cfg_pkg::word_t     inst1,
    input  core_cfg_pkg::reg_addr_t dbg_reg_num,
    output logic                    commit_valid,
    output logic                    commit_we0,
    output core_cfg_pkg::reg_addr_t commit_addr0,
    output core_cfg_pkg::word_t     commit_data0,
    output logic                    commit_we1,
    output core_cfg_pkg::reg_addr_t commit_addr1,
    output core_cfg_pkg::word_t     commit_data1,
    output core_cfg_pkg::word_t     dbg_reg_data
);
    import core_cfg_pkg::*;

    reg_addr_t rj0, rk0, rd0, rj1, rk1, rd1;
    word_t     rrj0, rrk0, rrd0, rrj1, rrk1, rrd1;

    issue_slot_if slot (.clk(clk));
    wb_port_if    ex_fwd ();
    wb_port_if    wb ();

    register_file i_rf (
        .clk          (clk),
        .rstn         (rstn),
        .wb           (wb.snk),
        .rj0          (rj0),
        .rk0          (rk0),
        .rd0          (rd0),
        .rj1          (rj1),
        .rk1          (rk1),
        .rd1          (rd1),
        .dbg_reg_num  (dbg_reg_num),
        .rrj0         (rrj0),
        .rrk0         (rrk0),
        .rrd0         (rrd0),
        .rrj1         (rrj1),
        .rrk1         (rrk1),
        .rrd1         (rrd1),
        .dbg_reg_data (dbg_reg_data)
    );

    dual_decode i_decode (
        .clk         (clk),
        .rstn        (rstn),
        .issue_valid (issue_valid),
        .inst0       (inst0),
        .inst1       (inst1),
        .rj0         (rj0),
        .rk0         (rk0),
        .rd0         (rd0),
        .rj1         (rj1),
        .rk1         (rk1),
        .rd1         (rd1),
        .rrj0        (rrj0),
        .rrk0        (rrk0),
        .rrd0        (rrd0),
        .rrj1        (rrj1),
        .rrk1        (rrk1),
        .rrd1        (rrd1),
        .ex_fwd      (ex_fwd.snk),
        .slot        (slot.stage_out)
    );

    dual_execute i_execute (
        .slot   (slot.stage_in),
        .ex_fwd (ex_fwd.src)
    );

    dual_result i_result (
        .clk          (clk),
        .rstn         (rstn),
        .ex_fwd       (ex_fwd.snk),
        .wb           (wb.src),
        .commit_valid (commit_valid)
    );

    // Commit view of the writeback port
    assign commit_we0   = wb.en0;
    assign commit_addr0 = wb.addr0;
    assign commit_data0 = wb.data0;
    assign commit_we1   = wb.en1;
    assign commit_addr1 = wb.addr1;
    assign commit_data1 = wb.data1;

endmodule

// ==== hdl/dual_result.sv ====
`timescale 1ns/1ns

module dual_result (
    input  logic   clk,
    input  logic   rstn,
    wb_port_if.snk ex_fwd,
    wb_port_if.src wb,
    output logic   commit_valid
);
    import core_cfg_pkg::*;

    logic same_dst;

    // Both lanes writing one register, lane 0 drops out
    assign same_dst = ex_fwd.en0 && ex_fwd.en1 && (ex_fwd.addr0 == ex_fwd.addr1);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wb.pair_valid <= 1'b0;
            wb.en0        <= 1'b0;
            wb.en1        <= 1'b0;
        end else begin
            wb.pair_valid <= ex_fwd.pair_valid;
            wb.en0        <= ex_fwd.en0 && !same_dst;
            wb.en1        <= ex_fwd.en1;
        end
    end

    always_ff @(posedge clk) begin
        wb.addr0 <= ex_fwd.addr0;
        wb.data0 <= ex_fwd.data0;
        wb.addr1 <= ex_fwd.addr1;
        wb.data1 <= ex_fwd.data1;
    end

    assign commit_valid = wb.pair_valid;   // Set even when nothing writes

    // Writes only with a valid pair, never to r0
    a_wb_legal: assert property (
        @(posedge clk) disable iff (!rstn)
        !((wb.en0 || wb.en1) && !wb.pair_valid)
        && !(wb.en0 && (wb.addr0 == '0)) && !(wb.en1 && (wb.addr1 == '0))
    ) else $error("writeback enable without a valid pair or aimed at r0");

endmodule

// ==== hdl/dual_execute.sv ====
`timescale 1ns/1ns

module dual_execute (
    issue_slot_if.stage_in slot,
    wb_port_if.src         ex_fwd
);
    import core_cfg_pkg::*;
    import la32_isa_pkg::*;

    word_t res [2];

    function automatic word_t alu(alu_op_e op, word_t a, word_t b);
        word_t r;
        case (op)
            op_add:  r = a + b;
            op_sub:  r = a - b;
            op_slt:  r = word_t'($signed(a) < $signed(b));
            op_sltu: r = word_t'(a < b);
            op_and:  r = a & b;
            op_or:   r = a | b;
            op_xor:  r = a ^ b;
            op_lui:  r = {b[I20_W-1:0], {(XLEN-I20_W){1'b0}}};
            default: r = '0;
        endcase
        return r;
    endfunction

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            res[i] = alu(slot.op[i], slot.src_a[i], slot.src_b[i]);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Forwarding / result port
    assign ex_fwd.pair_valid = slot.valid[0] | slot.valid[1];

    assign ex_fwd.en0   = slot.valid[0] && slot.wr[0] && (slot.dst[0] != '0);  // r0 never
    assign ex_fwd.addr0 = slot.dst[0];
    assign ex_fwd.data0 = res[0];

    assign ex_fwd.en1   = slot.valid[1] && slot.wr[1] && (slot.dst[1] != '0);
    assign ex_fwd.addr1 = slot.dst[1];
    assign ex_fwd.data1 = res[1];

    a_nop_no_write: assert property (
        @(posedge slot.clk)
        !((slot.wr[0] && (slot.op[0] == op_nop)) || (slot.wr[1] && (slot.op[1] == op_nop)))
    ) else $error("nop issued with write enable");

endmodule

// ==== hdl/dual_decode.sv ====
`timescale 1ns/1ns

module dual_decode (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    issue_valid,
    input  core_cfg_pkg::word_t     inst0,
    input  core_cfg_pkg::word_t     inst1,
    output core_cfg_pkg::reg_addr_t rj0,
    output core_cfg_pkg::reg_addr_t rk0,
    output core_cfg_pkg::reg_addr_t rd0,
    output core_cfg_pkg::reg_addr_t rj1,
    output core_cfg_pkg::reg_addr_t rk1,
    output core_cfg_pkg::reg_addr_t rd1,
    input  core_cfg_pkg::word_t     rrj0,
    input  core_cfg_pkg::word_t     rrk0,
    input  core_cfg_pkg::word_t     rrd0,
    input  core_cfg_pkg::word_t     rrj1,
    input  core_cfg_pkg::word_t     rrk1,
    input  core_cfg_pkg::word_t     rrd1,
    wb_port_if.snk                  ex_fwd,
    issue_slot_if.stage_out         slot
);
    import core_cfg_pkg::*;
    import la32_isa_pkg::*;

    typedef struct packed {
        alu_op_e op;
        logic    use_imm;
        word_t   imm;
    } dec_t;

    dec_t      dec   [2];
    word_t     a_d   [2];
    word_t     b_d   [2];
    reg_addr_t dst_d [2];

    function automatic dec_t decode_word(word_t w);
        dec_t d;
        d.op      = op_nop;
        d.use_imm = 1'b0;
        d.imm     = '0;
        case (w[OP3R_LSB +: OP3R_W])
            OPC_ADD_W: d.op = op_add;
            OPC_SUB_W: d.op = op_sub;
            OPC_SLT:   d.op = op_slt;
            OPC_SLTU:  d.op = op_sltu;
            OPC_AND:   d.op = op_and;
            OPC_OR:    d.op = op_or;
            OPC_XOR:   d.op = op_xor;
            default:   ;
        endcase
        if (w[OP12_LSB +: OP12_W] == OPC_ADDI_W) begin
            d.op      = op_add;
            d.use_imm = 1'b1;
            d.imm     = {{(XLEN-I12_W){w[I12_LSB+I12_W-1]}}, w[I12_LSB +: I12_W]};
        end
        if (w[OP12_LSB +: OP12_W] == OPC_ORI) begin
            d.op      = op_or;
            d.use_imm = 1'b1;
            d.imm     = word_t'(w[I12_LSB +: I12_W]);   // ui12, zero extended
        end
        if (w[OP20_LSB +: OP20_W] == OPC_LU12I_W) begin
            d.op      = op_lui;                          // Shifted up in the ALU
            d.use_imm = 1'b1;
            d.imm     = word_t'(w[I20_LSB +: I20_W]);
        end
        return d;
    endfunction

    // Execute-stage result overrides the register file, lane 1 first
    function automatic word_t fwd(reg_addr_t a, word_t rf_val);
        word_t v;
        if (ex_fwd.en1 && (ex_fwd.addr1 == a)) begin
            v = ex_fwd.data1;
        end else if (ex_fwd.en0 && (ex_fwd.addr0 == a)) begin
            v = ex_fwd.data0;
        end else begin
            v = rf_val;
        end
        return v;
    endfunction

    assign rj0 = inst0[RJ_LSB +: REG_AW];
    assign rk0 = inst0[RK_LSB +: REG_AW];
    assign rd0 = inst0[RD_LSB +: REG_AW];
    assign rj1 = inst1[RJ_LSB +: REG_AW];
    assign rk1 = inst1[RK_LSB +: REG_AW];
    assign rd1 = inst1[RD_LSB +: REG_AW];
    // rrd0 and rrd1 stay unread, no instruction here sources rd

    always_comb begin
        dec[0]   = decode_word(inst0);
        dec[1]   = decode_word(inst1);
        a_d[0]   = fwd(rj0, rrj0);
        a_d[1]   = fwd(rj1, rrj1);
        b_d[0]   = dec[0].use_imm ? dec[0].imm : fwd(rk0, rrk0);
        b_d[1]   = dec[1].use_imm ? dec[1].imm : fwd(rk1, rrk1);
        dst_d[0] = rd0;
        dst_d[1] = rd1;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Issue slot registers
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            slot.valid <= '0;
            slot.wr    <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                slot.valid[i] <= issue_valid;
                slot.wr[i]    <= dec[i].op != op_nop;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            slot.op[i]    <= dec[i].op;
            slot.src_a[i] <= a_d[i];
            slot.src_b[i] <= b_d[i];
            slot.dst[i]   <= dst_d[i];
        end
    end

endmodule

// ==== hdl/register_file.sv ====
`timescale 1ns/1ns

module register_file (
    input  logic                    clk,
    input  logic                    rstn,
    wb_port_if.snk                  wb,
    input  core_cfg_pkg::reg_addr_t rj0,
    input  core_cfg_pkg::reg_addr_t rk0,
    input  core_cfg_pkg::reg_addr_t rd0,
    input  core_cfg_pkg::reg_addr_t rj1,
    input  core_cfg_pkg::reg_addr_t rk1,
    input  core_cfg_pkg::reg_addr_t rd1,
    input  core_cfg_pkg::reg_addr_t dbg_reg_num,
    output core_cfg_pkg::word_t     rrj0,
    output core_cfg_pkg::word_t     rrk0,
    output core_cfg_pkg::word_t     rrd0,
    output core_cfg_pkg::word_t     rrj1,
    output core_cfg_pkg::word_t     rrk1,
    output core_cfg_pkg::word_t     rrd1,
    output core_cfg_pkg::word_t     dbg_reg_data
);
    import core_cfg_pkg::*;

    word_t rf [NREG];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write ports
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < NREG; i++) begin
                rf[i] <= '0;
            end
        end else begin
            if (wb.en0 && (wb.addr0 != '0)) begin
                rf[wb.addr0] <= wb.data0;
            end
            // Lane 1 last, so it wins on a shared address
            if (wb.en1 && (wb.addr1 != '0)) begin
                rf[wb.addr1] <= wb.data1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read ports with write-through
    function automatic word_t read_port(reg_addr_t a);
        word_t v;
        if (a == '0) begin
            v = '0;
        end else if (wb.en1 && (wb.addr1 == a)) begin
            v = wb.data1;
        end else if (wb.en0 && (wb.addr0 == a)) begin
            v = wb.data0;
        end else begin
            v = rf[a];
        end
        return v;
    endfunction

    always_comb begin
        rrj0 = read_port(rj0);
        rrk0 = read_port(rk0);
        rrd0 = read_port(rd0);
        rrj1 = read_port(rj1);
        rrk1 = read_port(rk1);
        rrd1 = read_port(rd1);
    end

    assign dbg_reg_data = rf[dbg_reg_num];   // Stored state, no bypass

    a_wb_addr_known: assert property (
        @(posedge clk) disable iff (!rstn)
        (wb.en0 |-> !$isunknown(wb.addr0)) and (wb.en1 |-> !$isunknown(wb.addr1))
    ) else $error("write enable with unknown register address");

endmodule

// ==== hdl/wb_port_if.sv ====
`timescale 1ns/1ns

interface wb_port_if;
    import core_cfg_pkg::*;

    logic      pair_valid;
    logic      en0;
    reg_addr_t addr0;
    word_t     data0;
    logic      en1;
    reg_addr_t addr1;
    word_t     data1;

    modport src (output pair_valid, en0, addr0, data0, en1, addr1, data1);
    modport snk (input  pair_valid, en0, addr0, data0, en1, addr1, data1);

endinterface

// ==== hdl/issue_slot_if.sv ====
`timescale 1ns/1ns

// Decoded pair, lane index 0 and 1
interface issue_slot_if (
    input logic clk
);
    import core_cfg_pkg::*;
    import la32_isa_pkg::*;

    logic [1:0] valid;
    alu_op_e    op    [2];
    word_t      src_a [2];  // rj value
    word_t      src_b [2];  // rk value or extended immediate
    reg_addr_t  dst   [2];
    logic [1:0] wr;

    modport stage_out (
        output valid, op, src_a, src_b, dst, wr
    );

    modport stage_in (
        input clk, valid, op, src_a, src_b, dst, wr
    );

endinterface

// ==== hdl/la32_isa_pkg.sv ====
package la32_isa_pkg;

    typedef enum logic [3:0] {
        op_nop,
        op_add,
        op_sub,
        op_slt,
        op_sltu,
        op_and,
        op_or,
        op_xor,
        op_lui
    } alu_op_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Major opcode fields
    localparam int OP3R_LSB = 15;   // 3R, bits 31:15
    localparam int OP3R_W   = 17;
    localparam int OP12_LSB = 22;   // 2RI12, bits 31:22
    localparam int OP12_W   = 10;
    localparam int OP20_LSB = 25;   // 1RI20, bits 31:25
    localparam int OP20_W   = 7;

    localparam logic [OP3R_W-1:0] OPC_ADD_W  = 17'h00020;
    localparam logic [OP3R_W-1:0] OPC_SUB_W  = 17'h00022;
    localparam logic [OP3R_W-1:0] OPC_SLT    = 17'h00024;
    localparam logic [OP3R_W-1:0] OPC_SLTU   = 17'h00025;
    localparam logic [OP3R_W-1:0] OPC_AND    = 17'h00029;
    localparam logic [OP3R_W-1:0] OPC_OR     = 17'h0002a;
    localparam logic [OP3R_W-1:0] OPC_XOR    = 17'h0002b;
    localparam logic [OP12_W-1:0] OPC_ADDI_W = 10'h00a;
    localparam logic [OP12_W-1:0] OPC_ORI    = 10'h00e;
    localparam logic [OP20_W-1:0] OPC_LU12I_W = 7'h0a;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operand fields
    localparam int RD_LSB  = 0;
    localparam int RJ_LSB  = 5;
    localparam int RK_LSB  = 10;
    localparam int I12_LSB = 10;    // si12 / ui12
    localparam int I12_W   = 12;
    localparam int I20_LSB = 5;     // si20
    localparam int I20_W   = 20;

endpackage

// ==== hdl/core_cfg_pkg.sv ====
package core_cfg_pkg;

    localparam int XLEN   = 32;
    localparam int NREG   = 32;
    localparam int REG_AW = 5;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

endpackage
